// File: all.f
hdl/adc_pkg.sv
hdl/phase_tracker.sv
hdl/lane_selector.sv
hdl/frame_packer.sv
hdl/adc_decimator.sv
tests/frame_checker.sv
tests/tb_adc_decimator.sv

// File: hdl/adc_decimator.sv
// Top of the decimating capture front end, chains phase tracking, lane pick and frame packing
`timescale 1ns/1ns
`default_nettype none

module adc_decimator (
    input  logic              CpSl_Clk_i,
    input  logic              rst_n_i,
    input  logic              trig_i,          // Capture run level
    input  adc_pkg::factor_t  dec_factor_i,    // Latched at run start
    input  adc_pkg::adc_bus_t adc_data_i,      // Four channel words
    output adc_pkg::frame_t   frame_o,
    output logic              frame_vld_o      // 3 cycles after the completing word
);
    import adc_pkg::*;

    phase_t phase;    // Valid one cycle after its word
    pick_t  pick;     // Valid two cycles after its word

    phase_tracker u_phase_tracker (
        .CpSl_Clk_i   (CpSl_Clk_i),
        .rst_n_i      (rst_n_i),
        .trig_i       (trig_i),
        .dec_factor_i (dec_factor_i),
        .phase_o      (phase)
    );

    lane_selector u_lane_selector (
        .CpSl_Clk_i (CpSl_Clk_i),
        .rst_n_i    (rst_n_i),
        .adc_data_i (adc_data_i),
        .phase_i    (phase),
        .pick_o     (pick)
    );

    frame_packer u_frame_packer (
        .CpSl_Clk_i  (CpSl_Clk_i),
        .rst_n_i     (rst_n_i),
        .pick_i      (pick),
        .frame_o     (frame_o),
        .frame_vld_o (frame_vld_o)
    );

endmodule

`default_nettype wire

// File: hdl/adc_pkg.sv
// Shared sizes, sample types and stage structs for the ADC decimating capture path
`default_nettype none

package adc_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int NUM_CH     = 4;    // ADC channels
    localparam int LANES      = 4;    // Samples per channel word
    localparam int SAMPLE_W   = 16;   // Bits per sample
    localparam int FACTOR_W   = 9;    // Decimation factor width
    localparam int MIN_FACTOR = 4;    // Keeps at most one sample per word

    // ----------------------------------------
    // Sample and word types
    // ----------------------------------------
    typedef logic [SAMPLE_W-1:0]        sample_t;
    typedef logic [$clog2(LANES)-1:0]   lane_t;
    typedef logic [FACTOR_W-1:0]        factor_t;

    // Lane 0 is the oldest sample, in the low bits
    typedef sample_t [LANES-1:0]        adc_word_t;
    typedef adc_word_t [NUM_CH-1:0]     adc_bus_t;

    // Channel c, slot j holds kept sample j of that channel
    typedef sample_t [NUM_CH-1:0][LANES-1:0] frame_t;

    // ----------------------------------------
    // Stage structs
    // ----------------------------------------
    typedef struct packed {
        logic  run;     // Capture run active
        logic  hit;     // Word holds a kept sample
        lane_t lane;    // Lane of the kept sample
    } phase_t;

    typedef struct packed {
        logic                    run;      // Capture run active
        logic                    vld;      // Kept sample this cycle
        sample_t [NUM_CH-1:0]    samples;  // One per channel
    } pick_t;

endpackage

`default_nettype wire

// File: hdl/frame_packer.sv
// Collects four kept samples per channel into one frame and strobes it out
`timescale 1ns/1ns
`default_nettype none

module frame_packer (
    input  logic            CpSl_Clk_i,
    input  logic            rst_n_i,
    input  adc_pkg::pick_t  pick_i,
    output adc_pkg::frame_t frame_o,        // Stable while frame_vld_o is high
    output logic            frame_vld_o     // One cycle per complete frame
);
    import adc_pkg::*;

    lane_t slot_q;    // Next slot to fill, 0 to 3
    logic  last_slot;

    assign last_slot = (slot_q == lane_t'(LANES - 1));

    // ----------------------------------------
    // Slot fill and frame strobe
    // ----------------------------------------
    // A partial frame left at the end of a run is dropped by
    // clearing the slot count while run is low
    always_ff @(posedge CpSl_Clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_q      <= '0;
            frame_o     <= '0;
            frame_vld_o <= 1'b0;
        end else begin
            frame_vld_o <= 1'b0;

            if (!pick_i.run) begin
                slot_q <= '0;
            end else if (pick_i.vld) begin
                for (int c = 0; c < NUM_CH; c++) begin
                    frame_o[c][slot_q] <= pick_i.samples[c];
                end
                slot_q      <= slot_q + 1'b1;    // Wraps to 0 after slot 3
                frame_vld_o <= last_slot;
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_vld_single : assert property (
        @(posedge CpSl_Clk_i) disable iff (!rst_n_i)
        frame_vld_o |=> !frame_vld_o
    );

endmodule

`default_nettype wire

// File: hdl/lane_selector.sv
// Delays the channel words to line up with the phase and picks the kept sample per channel
`timescale 1ns/1ns
`default_nettype none

module lane_selector (
    input  logic              CpSl_Clk_i,
    input  logic              rst_n_i,
    input  adc_pkg::adc_bus_t adc_data_i,    // Valid every cycle
    input  adc_pkg::phase_t   phase_i,       // One cycle behind adc_data_i
    output adc_pkg::pick_t    pick_o
);
    import adc_pkg::*;

    adc_bus_t             data_q;    // Word aligned with phase_i
    sample_t [NUM_CH-1:0] sel;

    // ----------------------------------------
    // Input word delay
    // ----------------------------------------
    always_ff @(posedge CpSl_Clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_q <= '0;
        end else begin
            data_q <= adc_data_i;
        end
    end

    // Same lane on every channel, channels stay in lockstep
    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            sel[c] = data_q[c][phase_i.lane];
        end
    end

    // ----------------------------------------
    // Pick register
    // ----------------------------------------
    always_ff @(posedge CpSl_Clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pick_o <= '0;
        end else begin
            pick_o.run <= phase_i.run;
            pick_o.vld <= phase_i.hit;
            if (phase_i.hit) begin
                pick_o.samples <= sel;    // Hold last pick otherwise
            end
        end
    end

    a_vld_in_run : assert property (
        @(posedge CpSl_Clk_i) disable iff (!rst_n_i)
        $rose(pick_o.vld) |-> pick_o.run
    );

endmodule

`default_nettype wire

// File: hdl/phase_tracker.sv
// Latches the decimation factor per run and marks the lane of each kept sample
`timescale 1ns/1ns
`default_nettype none

module phase_tracker (
    input  logic             CpSl_Clk_i,
    input  logic             rst_n_i,
    input  logic             trig_i,          // Capture run level
    input  adc_pkg::factor_t dec_factor_i,    // Read on first cycle of a run
    output adc_pkg::phase_t  phase_o
);
    import adc_pkg::*;

    factor_t             fac_q;      // Factor latched for this run
    logic [FACTOR_W-1:0] cnt_q;      // Offset of next kept sample from lane 0
    factor_t             cur_fac;
    logic [FACTOR_W-1:0] cur_cnt;
    logic [FACTOR_W-1:0] nxt_cnt;
    logic                run_start;
    logic                cur_hit;

    // ----------------------------------------
    // Phase for the current word
    // ----------------------------------------
    // On the first run cycle the count restarts at 0 and the new
    // factor is used straight from the port
    always_comb begin
        run_start = trig_i && !phase_o.run;
        cur_fac   = run_start ? dec_factor_i : fac_q;
        cur_cnt   = run_start ? '0 : cnt_q;
        cur_hit   = (cur_cnt < FACTOR_W'(LANES));

        if (cur_hit) begin
            // Next kept sample is one factor later, seen from the next word
            nxt_cnt = cur_cnt + cur_fac - FACTOR_W'(LANES);
        end else begin
            nxt_cnt = cur_cnt - FACTOR_W'(LANES);
        end
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge CpSl_Clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fac_q   <= '0;
            cnt_q   <= '0;
            phase_o <= '0;
        end else begin
            phase_o.run  <= trig_i;
            phase_o.hit  <= trig_i && cur_hit;
            phase_o.lane <= lane_t'(cur_cnt);    // Only meaningful with hit

            if (run_start) begin
                fac_q <= dec_factor_i;
            end

            cnt_q <= nxt_cnt;    // Restarted at 0 by run_start
        end
    end

    // Factor below 4 would allow two kept samples in one word
    a_factor_legal : assert property (
        @(posedge CpSl_Clk_i) disable iff (!rst_n_i)
        phase_o.run |-> (fac_q >= FACTOR_W'(MIN_FACTOR))
    );

    a_hit_in_run : assert property (
        @(posedge CpSl_Clk_i) disable iff (!rst_n_i)
        !phase_o.run |-> !phase_o.hit
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the simulation with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_adc_decimator \
    -Mdir obj_dir \
    -o sim_adc_decimator
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_adc_decimator)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: tests/frame_checker.sv
// Testbench monitor that models the decimation from the DUT inputs and checks every frame
`timescale 1ns/1ns
`default_nettype none

module frame_checker (
    input logic              CpSl_Clk_i,
    input logic              rst_n_i,
    input logic              trig_i,
    input adc_pkg::factor_t  dec_factor_i,
    input adc_pkg::adc_bus_t adc_data_i,
    input adc_pkg::frame_t   frame_o,
    input logic              frame_vld_o
);
    import adc_pkg::*;

    frame_t exp_q[$];               // Expected frames, oldest first
    int     due_q[$];               // Rising edge that closes each strobe period
    string  test_name    = "reset";
    int     err_cnt      = 0;
    int     frames_seen  = 0;
    int     err_start    = 0;
    int     frames_start = 0;

    int     cyc    = 0;             // Rising edges seen so far
    logic   run_q  = 1'b0;          // Trigger level of the previous word
    int     word_k = 0;             // Word number inside the run
    int     fac_l  = MIN_FACTOR;    // Factor of the current run
    lane_t  slot   = '0;
    frame_t part   = '0;            // Frame being gathered

    // ----------------------------------------
    // Reference model, one word per rising edge
    // ----------------------------------------
    always @(posedge CpSl_Clk_i) begin
        cyc = cyc + 1;
        if (!rst_n_i) begin
            run_q = 1'b0;
            slot  = '0;
        end else begin
            if (trig_i) begin
                if (!run_q) begin    // First word of a run
                    word_k = 0;
                    fac_l  = int'(dec_factor_i);
                    slot   = '0;
                end
                // Sample number 4k+l is kept when the factor divides it
                for (int l = 0; l < LANES; l++) begin
                    if ((LANES * word_k + l) % fac_l == 0) begin
                        for (int c = 0; c < NUM_CH; c++) begin
                            part[c][slot] = adc_data_i[c][l];
                        end
                        if (slot == lane_t'(LANES - 1)) begin
                            exp_q.push_back(part);
                            due_q.push_back(cyc + 3);
                        end
                        slot = slot + 1'b1;
                    end
                end
                word_k = word_k + 1;
            end else begin
                slot = '0;    // Partial frame dropped
            end
            run_q = trig_i;
        end
    end

    // ----------------------------------------
    // Output compare, away from the rising edge
    // ----------------------------------------
    always @(negedge CpSl_Clk_i) begin
        frame_t exp_f;
        int     due;
        if (rst_n_i && $isunknown(frame_vld_o)) begin
            $display("%s: frame_vld_o is unknown at cycle %0d", test_name, cyc);
            err_cnt++;
        end else if (rst_n_i && frame_vld_o) begin
            if (exp_q.size() == 0) begin
                $display("%s: unexpected frame at cycle %0d", test_name, cyc + 1);
                err_cnt++;
            end else begin
                exp_f = exp_q.pop_front();
                due   = due_q.pop_front();
                frames_seen++;
                if (frame_o !== exp_f) begin
                    $display("FAILED %s frame: expected %h, actual %h",
                             test_name, exp_f, frame_o);
                    err_cnt++;
                end
                // Strobe period closes at edge k+3
                if (cyc + 1 != due) begin
                    $display("FAILED %s strobe edge: expected %0d, actual %0d",
                             test_name, due, cyc + 1);
                    err_cnt++;
                end
            end
        end
    end

    task automatic begin_test(input string name);
        test_name    = name;
        err_start    = err_cnt;
        frames_start = frames_seen;
    endtask

    task automatic end_test(output int errs, output int frames);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected frames never appeared", test_name, exp_q.size());
            err_cnt++;
            exp_q.delete();
            due_q.delete();
        end
        errs   = err_cnt - err_start;
        frames = frames_seen - frames_start;
    endtask

endmodule

`default_nettype wire

// File: tests/tb_adc_decimator.sv
// Testbench top: clock, reset, random ADC words, capture runs, timeout and final report
`timescale 1ns/1ns
`default_nettype none

module tb_adc_decimator;
    import adc_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 20;
    localparam int NUM_TESTS    = 5;
    localparam int RUN_CYCLES   = 64 + 200 + 700 + 20 + 100;    // All capture runs
    localparam int LIMIT        = RUN_CYCLES + 30 * NUM_TESTS + RESET_CYCLES;

    logic     CpSl_Clk_i;
    logic     rst_n_i;
    logic     trig_i;
    factor_t  dec_factor_i;
    adc_bus_t adc_data_i;
    frame_t   frame_o;
    logic     frame_vld_o;

    integer seed         = 32'h8bc2_d257;
    int     cyc          = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     count_errs   = 0;    // Frame count mismatches

    adc_decimator u_adc_decimator (
        .CpSl_Clk_i   (CpSl_Clk_i),
        .rst_n_i      (rst_n_i),
        .trig_i       (trig_i),
        .dec_factor_i (dec_factor_i),
        .adc_data_i   (adc_data_i),
        .frame_o      (frame_o),
        .frame_vld_o  (frame_vld_o)
    );

    frame_checker u_checker (
        .CpSl_Clk_i   (CpSl_Clk_i),
        .rst_n_i      (rst_n_i),
        .trig_i       (trig_i),
        .dec_factor_i (dec_factor_i),
        .adc_data_i   (adc_data_i),
        .frame_o      (frame_o),
        .frame_vld_o  (frame_vld_o)
    );

    // ----------------------------------------
    // Clock, ADC words and timeout
    // ----------------------------------------
    initial begin
        CpSl_Clk_i = 1'b0;
        forever #4 CpSl_Clk_i = ~CpSl_Clk_i;    // 8 ns period
    end

    function automatic adc_bus_t rand_bus();
        logic [$bits(adc_bus_t)-1:0] flat;
        for (int w = 0; w < $bits(adc_bus_t) / 32; w++) begin
            flat[w*32 +: 32] = $random(seed);
        end
        return adc_bus_t'(flat);
    endfunction

    initial begin
        adc_data_i = '0;
        forever begin
            @(negedge CpSl_Clk_i);
            adc_data_i = rand_bus();    // New word every cycle
        end
    end

    initial begin
        while (cyc < LIMIT) begin
            @(posedge CpSl_Clk_i);
            cyc++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Kept samples are 0, fac, 2*fac ... below 4*len, grouped by four
    function automatic int frames_for(input int fac, input int len);
        return ((LANES * len + fac - 1) / fac) / LANES;
    endfunction

    task automatic drive_run(input factor_t fac, input int len,
                             input int chg_at, input factor_t chg_fac);
        for (int i = 0; i < len; i++) begin
            @(negedge CpSl_Clk_i);
            trig_i       = 1'b1;
            dec_factor_i = (chg_at >= 0 && i >= chg_at) ? chg_fac : fac;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge CpSl_Clk_i);
            trig_i = 1'b0;
        end
    endtask

    task automatic close_test(input string name, input int exp_frames);
        int errs;
        int frames;
        u_checker.end_test(errs, frames);
        if (frames != exp_frames) begin
            $display("FAILED %s frame count: expected %0d, actual %0d",
                     name, exp_frames, frames);
            errs++;
            count_errs++;
        end
        tests_run++;
        if (errs == 0) begin
            $display("test %-10s pass, %0d frames", name, frames);
        end else begin
            tests_failed++;
            $display("test %-10s fail, %0d errors", name, errs);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rst_n_i      = 1'b0;
        trig_i       = 1'b0;
        dec_factor_i = factor_t'(MIN_FACTOR);
        repeat (RESET_CYCLES) @(negedge CpSl_Clk_i);
        rst_n_i = 1'b1;

        u_checker.begin_test("idle");
        idle(IDLE_CYCLES);
        close_test("idle", 0);

        u_checker.begin_test("factor_4");
        drive_run(9'd4, 64, -1, 9'd0);
        idle(IDLE_CYCLES);
        close_test("factor_4", frames_for(4, 64));

        u_checker.begin_test("factor_7");
        drive_run(9'd7, 200, -1, 9'd0);
        idle(IDLE_CYCLES);
        close_test("factor_7", frames_for(7, 200));

        u_checker.begin_test("factor_300");
        drive_run(9'd300, 700, -1, 9'd0);
        idle(IDLE_CYCLES);
        close_test("factor_300", frames_for(300, 700));

        // First run ends one sample into a frame, second changes factor midway
        u_checker.begin_test("restart");
        drive_run(9'd9, 20, -1, 9'd0);
        idle(2);
        drive_run(9'd5, 100, 50, 9'd13);
        idle(IDLE_CYCLES);
        close_test("restart", frames_for(9, 20) + frames_for(5, 100));

        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, u_checker.err_cnt + count_errs);
        if (tests_failed == 0 && u_checker.err_cnt + count_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
